// ==== source/dma_cfg.svh ====
// DMA initiator configuration

`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// Address on the local bus and in remote requests
`define DMA_ADDR_WIDTH 32

// One NoC flit payload, one stream word
`define DMA_DATA_WIDTH 32

// Transfer size in words, as carried in a header
`define DMA_SIZE_WIDTH 12

// Tile number on the NoC
`define DMA_TILE_WIDTH 5

//////////////////////////////////////////////////
// Table and packet limits
//////////////////////////////////////////////////

// Entries offered by the request table
`define DMA_TABLE_ENTRIES 4

// Flits per packet, header and address included
// Payload per packet is two less
`define DMA_NOC_PACKET_SIZE 16

// Number of this tile, goes into the source field
`define DMA_TILE_ID 0

`endif

// ==== source/dma_pkg.sv ====
// DMA request side types

`include "dma_cfg.svh"

package dma_pkg;

  // Plain vectors with a meaning
  typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DMA_DATA_WIDTH-1:0] data_t;
  typedef logic [`DMA_SIZE_WIDTH-1:0] size_t;
  typedef logic [`DMA_TILE_WIDTH-1:0] tile_t;

  // Table entry as index and as one bit per entry
  typedef logic [$clog2(`DMA_TABLE_ENTRIES)-1:0] entry_pos_t;
  typedef logic [`DMA_TABLE_ENTRIES-1:0] entry_mask_t;

  // Flit type in the top two bits of a flit
  typedef enum logic [1:0] {
    PAYLOAD = 2'b00,
    HEADER  = 2'b01,
    LAST    = 2'b10
  } flit_kind_e;

  // Packet types of the request side
  typedef enum logic [1:0] {
    L2R_REQ = 2'b00,
    R2L_REQ = 2'b01
  } packet_type_e;

  typedef enum logic [2:0] {
    DMA = 3'b010
  } packet_class_e;

  // One table entry with dir 0 for L2R and 1 for R2L
  typedef struct packed {
    logic  dir;
    addr_t laddr;
    size_t size;
    tile_t rtile;
    addr_t raddr;
  } dma_req_t;

  // Header flit content from dest at the top down to size
  typedef struct packed {
    tile_t         dest;
    packet_class_e pclass;
    tile_t         src;
    packet_type_e  ptype;
    logic [3:0]    id;
    logic          req_last;
    size_t         size;
  } dma_hdr_t;

  typedef struct packed {
    flit_kind_e kind;
    data_t      content;
  } noc_flit_t;

  // Next packet of the current request
  typedef struct packed {
    size_t pkt_size;
    logic  last;
    size_t offset;
  } pkt_plan_t;

  typedef enum logic [2:0] {
    IDLE,
    L2R_HDR,
    L2R_ADDR,
    L2R_DATA,
    R2L_HDR,
    R2L_SIZE,
    R2L_RADDR,
    R2L_LADDR
  } req_state_e;

endpackage

// ==== source/dma_entry_arbiter.sv ====
// Request table entry arbiter

`timescale 1ns/100ps

`include "dma_cfg.svh"

module dma_entry_arbiter
  import dma_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  entry_mask_t valid,
  input  logic        ctrl_done_en,
  input  entry_pos_t  ctrl_done_pos,
  input  logic        finish,
  input  logic        idle,
  output logic        start,
  output entry_pos_t  ctrl_read_pos
);

  // Entries issued and still waiting for their response
  entry_mask_t open_resp;
  // One-hot grant, held until the request is issued
  entry_mask_t grant;
  entry_mask_t cand;
  entry_pos_t  nxt_pos;
  logic        take;

  // Only valid entries without an open response compete
  assign cand = valid & ~open_resp;

  // New grant only while the FSM waits and no start is in flight
  assign take = idle & ~start & (|cand);

  //////////////////////////////////////////////////
  // Round-robin pick
  //////////////////////////////////////////////////

  // Walk backwards so the nearest candidate after the grant wins
  // Offset of a full turn lands on the old grant itself
  always_comb begin
    int idx;
    nxt_pos = ctrl_read_pos;
    for (int i = `DMA_TABLE_ENTRIES; i >= 1; i--) begin
      idx = (int'(ctrl_read_pos) + i) % `DMA_TABLE_ENTRIES;
      if (cand[idx]) begin
        nxt_pos = entry_pos_t'(idx);
      end
    end
  end

  // One-hot to binary
  always_comb begin
    ctrl_read_pos = '0;
    for (int d = 0; d < `DMA_TABLE_ENTRIES; d++) begin
      if (grant[d]) begin
        ctrl_read_pos = ctrl_read_pos | entry_pos_t'(d);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      grant <= entry_mask_t'(1);
      start <= 1'b0;
    end else begin
      start <= take;
      if (take) begin
        grant <= entry_mask_t'(1) << nxt_pos;
      end
    end
  end

  //////////////////////////////////////////////////
  // Open response tracking
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      open_resp <= '0;
    end else begin
      // Mark on finish, a done clears only its own bit
      open_resp <= open_resp | (finish ? grant : '0);
      if (ctrl_done_en) begin
        open_resp[ctrl_done_pos] <= 1'b0;
      end
    end
  end

endmodule

// ==== source/dma_packet_planner.sv ====
// L2R packet planner

`timescale 1ns/100ps

`include "dma_cfg.svh"

module dma_packet_planner
  import dma_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  size_t     size,
  input  logic      begin_req,
  input  logic      hdr_taken,
  input  logic      word_taken,
  output pkt_plan_t plan,
  output size_t     word_left
);

  // Payload words per packet, header and address take two flits
  localparam size_t max_payload = size_t'(`DMA_NOC_PACKET_SIZE - 2);

  // Words sent in packets already closed
  size_t sent;
  size_t unsent;

  assign unsent = size - sent;

  //////////////////////////////////////////////////
  // Next packet
  //////////////////////////////////////////////////

  // Full packet unless the tail fits in one
  always_comb begin
    plan.offset = sent;
    if (unsent > max_payload) begin
      plan.pkt_size = max_payload;
      plan.last     = 1'b0;
    end else begin
      plan.pkt_size = unsent;
      plan.last     = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Progress counters
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      sent      <= '0;
      word_left <= '0;
    end else if (begin_req) begin
      sent <= '0;
    end else if (hdr_taken) begin
      word_left <= plan.pkt_size;
    end else if (word_taken) begin
      word_left <= word_left - size_t'(1);
      // Packet closed, next one starts after it
      if (word_left == size_t'(1)) begin
        sent <= sent + plan.pkt_size;
      end
    end
  end

endmodule

// ==== source/dma_flit_fsm.sv ====
// NoC request flit generator

`timescale 1ns/100ps

`include "dma_cfg.svh"

module dma_flit_fsm
  import dma_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  dma_req_t   entry,
  input  entry_pos_t entry_id,
  input  pkt_plan_t  plan,
  input  size_t      word_left,
  input  logic       data_valid,
  input  data_t      data,
  output logic       data_ready,
  output noc_flit_t  noc_out_flit,
  output logic       noc_out_valid,
  input  logic       noc_out_ready,
  output logic       idle,
  output logic       finish,
  output logic       begin_req,
  output logic       hdr_taken,
  output logic       word_taken
);

  req_state_e request_state;
  req_state_e nxt_state;
  dma_hdr_t   hdr;
  logic       last_word;

  // Common header fields, type and size patched per direction
  always_comb begin
    hdr          = '0;
    hdr.dest     = entry.rtile;
    hdr.pclass   = DMA;
    hdr.id       = 4'(entry_id);
    hdr.src      = tile_t'(`DMA_TILE_ID);
    if (entry.dir) begin
      hdr.ptype    = R2L_REQ;
      hdr.req_last = 1'b1;
    end else begin
      hdr.ptype    = L2R_REQ;
      hdr.req_last = plan.last;
      hdr.size     = plan.pkt_size;
    end
  end

  assign last_word = (word_left == size_t'(1));

  // Handshake strobes for the arbiter and the planner
  assign idle       = (request_state == IDLE);
  assign begin_req  = idle & start;
  assign hdr_taken  = (request_state == L2R_HDR) & noc_out_ready;
  assign word_taken = (request_state == L2R_DATA) & data_valid & noc_out_ready;
  assign data_ready = word_taken;
  assign finish     = (word_taken & last_word & plan.last)
                    | ((request_state == R2L_LADDR) & noc_out_ready);

  //////////////////////////////////////////////////
  // Flit and next state
  //////////////////////////////////////////////////

  always_comb begin
    noc_out_flit  = '{kind: PAYLOAD, content: '0};
    noc_out_valid = 1'b1;
    nxt_state     = request_state;
    case (request_state)
      IDLE: begin
        noc_out_valid = 1'b0;
        if (start) begin
          nxt_state = entry.dir ? R2L_HDR : L2R_HDR;
        end
      end
      L2R_HDR: begin
        noc_out_flit = '{kind: HEADER, content: data_t'(hdr)};
        if (noc_out_ready) nxt_state = L2R_ADDR;
      end
      L2R_ADDR: begin
        // Word offset turned into a byte offset
        noc_out_flit.content = entry.raddr + (addr_t'(plan.offset) << 2);
        if (noc_out_ready) nxt_state = L2R_DATA;
      end
      L2R_DATA: begin
        // Stream stalls show up as gaps on the NoC
        noc_out_valid        = data_valid;
        noc_out_flit.kind    = last_word ? LAST : PAYLOAD;
        noc_out_flit.content = data;
        if (word_taken && last_word) begin
          nxt_state = plan.last ? IDLE : L2R_HDR;
        end
      end
      R2L_HDR: begin
        noc_out_flit = '{kind: HEADER, content: data_t'(hdr)};
        if (noc_out_ready) nxt_state = R2L_SIZE;
      end
      R2L_SIZE: begin
        noc_out_flit.content = data_t'(entry.size);
        if (noc_out_ready) nxt_state = R2L_RADDR;
      end
      R2L_RADDR: begin
        noc_out_flit.content = entry.raddr;
        if (noc_out_ready) nxt_state = R2L_LADDR;
      end
      R2L_LADDR: begin
        noc_out_flit = '{kind: LAST, content: entry.laddr};
        if (noc_out_ready) nxt_state = IDLE;
      end
      default: begin
        noc_out_valid = 1'b0;
        nxt_state     = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      request_state <= IDLE;
    end else begin
      request_state <= nxt_state;
    end
  end

endmodule

// ==== source/dma_initiator.sv ====
// DMA initiator request side

`timescale 1ns/100ps

module dma_initiator
  import dma_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  entry_mask_t valid,
  input  dma_req_t    ctrl_read_req,
  output entry_pos_t  ctrl_read_pos,
  input  logic        ctrl_done_en,
  input  entry_pos_t  ctrl_done_pos,
  input  logic        data_valid,
  input  data_t       data,
  output logic        data_ready,
  output noc_flit_t   noc_out_flit,
  output logic        noc_out_valid,
  input  logic        noc_out_ready
);

  // Arbiter and FSM handshake
  logic start;
  logic finish;
  logic idle;

  // FSM to planner progress strobes
  logic begin_req;
  logic hdr_taken;
  logic word_taken;

  pkt_plan_t plan;
  size_t     word_left;

  dma_entry_arbiter u_arbiter (
    .clk          (clk),
    .rst          (rst),
    .valid        (valid),
    .ctrl_done_en (ctrl_done_en),
    .ctrl_done_pos(ctrl_done_pos),
    .finish       (finish),
    .idle         (idle),
    .start        (start),
    .ctrl_read_pos(ctrl_read_pos)
  );

  // Entry follows the held grant, so size is stable per request
  dma_packet_planner u_planner (
    .clk       (clk),
    .rst       (rst),
    .size      (ctrl_read_req.size),
    .begin_req (begin_req),
    .hdr_taken (hdr_taken),
    .word_taken(word_taken),
    .plan      (plan),
    .word_left (word_left)
  );

  dma_flit_fsm u_fsm (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .entry        (ctrl_read_req),
    .entry_id     (ctrl_read_pos),
    .plan         (plan),
    .word_left    (word_left),
    .data_valid   (data_valid),
    .data         (data),
    .data_ready   (data_ready),
    .noc_out_flit (noc_out_flit),
    .noc_out_valid(noc_out_valid),
    .noc_out_ready(noc_out_ready),
    .idle         (idle),
    .finish       (finish),
    .begin_req    (begin_req),
    .hdr_taken    (hdr_taken),
    .word_taken   (word_taken)
  );

endmodule

// ==== verif/tb_dma_initiator.sv ====
// DMA initiator testbench

`timescale 1ns/100ps

`include "dma_cfg.svh"

module tb_dma_initiator
  import dma_pkg::*;
;

  localparam int          max_payload = `DMA_NOC_PACKET_SIZE - 2;
  localparam logic [31:0] seed        = 32'd83205;
  localparam data_t       first_data  = 32'hD000_0000;

  logic        clk = 1'b0;
  logic        rst;
  entry_mask_t valid;
  dma_req_t    ctrl_read_req;
  entry_pos_t  ctrl_read_pos;
  logic        ctrl_done_en;
  entry_pos_t  ctrl_done_pos;
  logic        data_valid = 1'b0;
  data_t       data = '0;
  logic        data_ready;
  noc_flit_t   noc_out_flit;
  logic        noc_out_valid;
  logic        noc_out_ready = 1'b0;

  // Request table model read combinationally at the grant
  dma_req_t    table_q [`DMA_TABLE_ENTRIES];
  entry_pos_t  exp_ids [$];
  logic [31:0] rng = seed;
  logic [31:0] bp_rng = ~seed;
  logic        bp_on = 1'b0;
  data_t       word_cnt = first_data;
  data_t       word_base = first_data;
  dma_req_t    cur_req;
  entry_pos_t  cur_id;
  noc_flit_t   held_flit;
  logic        held = 1'b0;
  int          flit_idx = 0;
  int          flit_checks = 0;
  int          reqs_seen = 0;
  int          reqs_expected = 0;
  int          flit_budget = 0;
  int          value_errors = 0;
  int          other_errors = 0;

  always #10 clk = ~clk;

  assign ctrl_read_req = table_q[ctrl_read_pos];

  dma_initiator UUT (
    .clk          (clk),
    .rst          (rst),
    .valid        (valid),
    .ctrl_read_req(ctrl_read_req),
    .ctrl_read_pos(ctrl_read_pos),
    .ctrl_done_en (ctrl_done_en),
    .ctrl_done_pos(ctrl_done_pos),
    .data_valid   (data_valid),
    .data         (data),
    .data_ready   (data_ready),
    .noc_out_flit (noc_out_flit),
    .noc_out_valid(noc_out_valid),
    .noc_out_ready(noc_out_ready)
  );

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Flits in one request with header and address added per L2R packet
  function automatic int ref_count(input dma_req_t req);
    int sz;
    sz = int'(req.size);
    if (req.dir) return 4;
    return sz + 2 * ((sz + max_payload - 1) / max_payload);
  endfunction

  // Flit n of a request with data words counting up from first_word
  function automatic noc_flit_t ref_flit(input dma_req_t req, input entry_pos_t id,
                                         input int n, input data_t first_word);
    dma_hdr_t  hdr;
    noc_flit_t f;
    int        sz;
    int        off;
    int        len;
    int        rem;
    sz         = int'(req.size);
    hdr        = '0;
    hdr.dest   = req.rtile;
    hdr.pclass = DMA;
    hdr.id     = 4'(id);
    hdr.src    = tile_t'(`DMA_TILE_ID);
    f          = '{kind: PAYLOAD, content: '0};
    if (req.dir) begin
      hdr.ptype    = R2L_REQ;
      hdr.req_last = 1'b1;
      case (n)
        0:       f = '{kind: HEADER, content: data_t'(hdr)};
        1:       f.content = data_t'(req.size);
        2:       f.content = req.raddr;
        default: f = '{kind: LAST, content: req.laddr};
      endcase
    end else begin
      // Skip whole packets until n falls inside one
      off = 0;
      rem = n;
      len = (sz > max_payload) ? max_payload : sz;
      while (rem >= len + 2) begin
        rem = rem - (len + 2);
        off = off + len;
        len = (sz - off > max_payload) ? max_payload : sz - off;
      end
      if (rem == 0) begin
        hdr.ptype    = L2R_REQ;
        hdr.req_last = (off + len == sz);
        hdr.size     = size_t'(len);
        f = '{kind: HEADER, content: data_t'(hdr)};
      end else if (rem == 1) begin
        f.content = req.raddr + addr_t'(4 * off);
      end else begin
        f.kind    = (rem - 2 == len - 1) ? LAST : PAYLOAD;
        f.content = first_word + data_t'(off + rem - 2);
      end
    end
    return f;
  endfunction

  function automatic dma_req_t make_req(input logic dir, input addr_t laddr, input int size,
                                        input tile_t rtile, input addr_t raddr);
    dma_req_t r;
    r.dir   = dir;
    r.laddr = laddr;
    r.size  = size_t'(size);
    r.rtile = rtile;
    r.raddr = raddr;
    return r;
  endfunction

  // Sizes from 1 to 20 so that some L2R entries need two packets
  function automatic dma_req_t random_req();
    dma_req_t r;
    rng     = lcg(rng);
    r.dir   = rng[29];
    r.rtile = tile_t'(rng[28:24]);
    r.size  = size_t'(32'd1 + (rng >> 8) % 32'd20);
    rng     = lcg(rng);
    r.raddr = rng & 32'hFFFF_FFFC;
    rng     = lcg(rng);
    r.laddr = rng & 32'hFFFF_FFFC;
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Stream source and NoC sink
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (bp_on) begin
      bp_rng = lcg(bp_rng);
      noc_out_ready <= bp_rng[26] | bp_rng[25];
      data_valid    <= bp_rng[24] | bp_rng[23];
    end else begin
      noc_out_ready <= 1'b1;
      data_valid    <= 1'b1;
    end
    data <= word_cnt;
  end

  // Word counter that moves on each accepted word
  always @(posedge clk) begin
    if (data_valid && data_ready) word_cnt <= word_cnt + 32'd1;
  end

  //////////////////////////////////////////////////
  // Comparison
  //////////////////////////////////////////////////

  task automatic check_accepted_flit();
    noc_flit_t exp_f;
    if (flit_idx == 0) begin
      assert (exp_ids.size() != 0) else begin
        other_errors++;
        $display("Flit %h accepted while no request was expected", noc_out_flit);
      end
      if (exp_ids.size() == 0) return;
      cur_id  = exp_ids.pop_front();
      cur_req = table_q[cur_id];
    end
    exp_f = ref_flit(cur_req, cur_id, flit_idx, word_base);
    assert (noc_out_flit.kind == exp_f.kind) else begin
      value_errors++;
      $display("[FAIL] noc_out_flit.kind: got %h expected %h (entry %0d flit %0d)",
               noc_out_flit.kind, exp_f.kind, cur_id, flit_idx);
    end
    assert (noc_out_flit.content == exp_f.content) else begin
      value_errors++;
      $display("[FAIL] noc_out_flit.content: got %h expected %h (entry %0d flit %0d)",
               noc_out_flit.content, exp_f.content, cur_id, flit_idx);
    end
    flit_checks++;
    flit_idx++;
    // Next request takes the stream words after this one
    if (flit_idx == ref_count(cur_req)) begin
      flit_idx = 0;
      if (!cur_req.dir) word_base = word_base + data_t'(cur_req.size);
      reqs_seen++;
    end
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      // A stalled flit stays put and only a stream gap may hide it
      if (held && noc_out_valid) begin
        assert (noc_out_flit == held_flit) else begin
          value_errors++;
          $display("[FAIL] noc_out_flit: got %h expected %h while stalled",
                   noc_out_flit, held_flit);
        end
      end
      if (held && !noc_out_valid) begin
        assert (!data_valid) else begin
          other_errors++;
          $display("noc_out_valid dropped before its flit was accepted");
        end
      end
      if (noc_out_valid && !noc_out_ready) begin
        held      = 1'b1;
        held_flit = noc_out_flit;
      end else if (noc_out_valid) begin
        held = 1'b0;
      end
      if (noc_out_valid && noc_out_ready) check_accepted_flit();
    end
  end

  //////////////////////////////////////////////////
  // Sequencing
  //////////////////////////////////////////////////

  task automatic expect_issue(input entry_pos_t p);
    exp_ids.push_back(p);
    reqs_expected++;
    flit_budget += ref_count(table_q[p]);
  endtask

  task automatic wait_requests();
    while (reqs_seen < reqs_expected) @(negedge clk);
  endtask

  // One-cycle done from the response side
  task automatic send_done(input entry_pos_t p);
    ctrl_done_en  = 1'b1;
    ctrl_done_pos = p;
    @(negedge clk);
    ctrl_done_en  = 1'b0;
  endtask

  task automatic print_counts();
    $display("Errors: %0d value, %0d other, over %0d flits of %0d requests",
             value_errors, other_errors, flit_checks, reqs_seen);
  endtask

  initial begin
    rst           = 1'b1;
    valid         = '0;
    ctrl_done_en  = 1'b0;
    ctrl_done_pos = '0;
    for (int i = 0; i < `DMA_TABLE_ENTRIES; i++) table_q[i] = '0;
    repeat (3) @(negedge clk);
    rst = 1'b0;

    // L2R of 5 words in one packet
    table_q[1] = make_req(1'b0, 32'h0000_1000, 5, 5'd3, 32'h8000_0000);
    valid = 4'b0010;
    expect_issue(entry_pos_t'(1));
    wait_requests();
    valid = '0;
    send_done(entry_pos_t'(1));

    // L2R of 30 words in packets of 14, 14 and 2
    table_q[2] = make_req(1'b0, 32'h0000_2000, 30, 5'd7, 32'h4000_0100);
    valid = 4'b0100;
    expect_issue(entry_pos_t'(2));
    wait_requests();
    valid = '0;
    send_done(entry_pos_t'(2));

    // R2L request of four flits
    table_q[3] = make_req(1'b1, 32'h0000_3000, 64, 5'd12, 32'h6000_0200);
    valid = 4'b1000;
    expect_issue(entry_pos_t'(3));
    wait_requests();
    valid = '0;
    send_done(entry_pos_t'(3));

    // All entries valid with rotation starting after entry 3
    for (int i = 0; i < `DMA_TABLE_ENTRIES; i++) table_q[i] = random_req();
    valid = 4'b1111;
    for (int i = 0; i < `DMA_TABLE_ENTRIES; i++) expect_issue(entry_pos_t'(i));
    wait_requests();
    // Any flit in this gap would be a reissue of an open entry
    repeat (20) @(negedge clk);
    send_done(entry_pos_t'(2));
    expect_issue(entry_pos_t'(2));
    wait_requests();
    repeat (20) @(negedge clk);
    valid = '0;
    for (int i = 0; i < `DMA_TABLE_ENTRIES; i++) send_done(entry_pos_t'(i));
    valid = 4'b1111;
    expect_issue(entry_pos_t'(3));
    expect_issue(entry_pos_t'(0));
    expect_issue(entry_pos_t'(1));
    expect_issue(entry_pos_t'(2));
    wait_requests();
    valid = '0;
    for (int i = 0; i < `DMA_TABLE_ENTRIES; i++) send_done(entry_pos_t'(i));

    // Random stalls on both handshakes
    for (int i = 1; i < `DMA_TABLE_ENTRIES; i++) table_q[i] = random_req();
    table_q[0] = make_req(1'b0, 32'h0000_4000, 20, 5'd9, 32'h2000_0000);
    bp_on = 1'b1;
    valid = 4'b1111;
    expect_issue(entry_pos_t'(3));
    expect_issue(entry_pos_t'(0));
    expect_issue(entry_pos_t'(1));
    expect_issue(entry_pos_t'(2));
    wait_requests();
    bp_on = 1'b0;
    valid = '0;
    repeat (5) @(negedge clk);

    print_counts();
    if (value_errors + other_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Limit grows with every expected request
  initial begin
    int cycles;
    cycles = 0;
    while (cycles <= flit_budget * 40 + 2000) begin
      @(posedge clk);
      cycles++;
    end
    other_errors++;
    $display("Timeout after %0d cycles, %0d of %0d requests seen",
             cycles, reqs_seen, reqs_expected);
    print_counts();
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+source
source/dma_pkg.sv
source/dma_entry_arbiter.sv
source/dma_packet_planner.sv
source/dma_flit_fsm.sv
source/dma_initiator.sv
verif/tb_dma_initiator.sv

// ==== Makefile ====
TOP = tb_dma_initiator

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f sources.f --top-module $(TOP) --Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
